/* common/dtim_macros.svh */
`ifndef DTIM_MACROS_SVH
`define DTIM_MACROS_SVH

// Line store geometry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// Index bits, the store holds 2**DTIM_DEPTH lines
`define DTIM_DEPTH 4

// Word offset bits, each line holds 2**DTIM_WIDTH 32-bit words
`define DTIM_WIDTH 2

// Cached address window
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// Base is inclusive and top is exclusive
// The window is larger than the line store, so indices alias inside it
`define DTIM_BASE_ADDR 32'h0000_1000
`define DTIM_TOP_ADDR 32'h0000_1400

`endif

/* common/dtim_pkg.sv */
`include "dtim_macros.svh"

package dtim_pkg;

  // Address splits into tag, index, word offset and byte offset
  localparam int tag_bits = 30 - `DTIM_DEPTH - `DTIM_WIDTH;
  localparam int line_bits = 32 * (2 ** `DTIM_WIDTH);

  // Per-line state, kept together in one array
  typedef struct packed {
    logic present;
    logic dirty;
  } dtim_flags_t;

  // Controller states
  typedef enum logic [2:0] {
    st_lookup,
    st_miss,
    st_bypass,
    st_update,
    st_fence,
    st_writeback
  } dtim_state_e;

endpackage

/* common/dtim_ram_if.sv */
`timescale 1ns/1ps
`include "dtim_macros.svh"

// Write and read side of one line-indexed array
interface dtim_ram_if #(
  parameter int data_bits = 1
);

  logic                   wen;
  logic [`DTIM_DEPTH-1:0] waddr;
  logic [`DTIM_DEPTH-1:0] raddr;
  logic [data_bits-1:0]   wdata;
  logic [data_bits-1:0]   rdata;

  modport ctrl (
    output wen,
    output waddr,
    output raddr,
    output wdata,
    input  rdata
  );

  modport array (
    input  wen,
    input  waddr,
    input  raddr,
    input  wdata,
    output rdata
  );

endinterface

/* logic/dtim_ram.sv */
`timescale 1ns/1ps
`include "dtim_macros.svh"

module dtim_ram (
  input logic       clock,
  dtim_ram_if.array ram
);

  localparam int data_bits = $bits(ram.wdata);
  localparam int entries = 2 ** `DTIM_DEPTH;

  logic [data_bits-1:0]   mem [entries] = '{default: '0};
  logic [`DTIM_DEPTH-1:0] raddr_q = '0;

  // The read address is captured at the edge, data follows in the next cycle
  always_ff @(posedge clock) begin
    raddr_q <= ram.raddr;
    if (ram.wen) begin
      mem[ram.waddr] <= ram.wdata;
    end
  end

  assign ram.rdata = mem[raddr_q];

endmodule

/* dtim/dtim_line_buf.sv */
`timescale 1ns/1ps
`include "dtim_macros.svh"

module dtim_line_buf (
  input  logic                           clock,
  input  logic [dtim_pkg::line_bits-1:0] line_in,
  input  logic                           load,
  input  logic                           fill,
  input  logic                           merge,
  input  logic [`DTIM_WIDTH-1:0]         word_sel,
  input  logic [31:0]                    fill_word,
  input  logic [31:0]                    store_data,
  input  logic [3:0]                     store_strb,
  output logic [dtim_pkg::line_bits-1:0] line_out,
  output logic [31:0]                    word_out
);

  logic [dtim_pkg::line_bits-1:0] line_q;
  logic [dtim_pkg::line_bits-1:0] line_d;

  always_comb begin
    line_d = line_q;

    // A whole line from the array or one refill word
    if (load) begin
      line_d = line_in;
    end else if (fill) begin
      line_d[32*word_sel +: 32] = fill_word;
    end

    // Store bytes land on top of whatever was taken above
    if (merge) begin
      for (int b = 0; b < 4; b++) begin
        if (store_strb[b]) begin
          line_d[32*word_sel + 8*b +: 8] = store_data[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    line_q <= line_d;
  end

  assign line_out = line_q;

  // Load data after a refill and writeback data both come from here
  assign word_out = line_q[32*word_sel +: 32];

endmodule

/* dtim/dtim_ctrl.sv */
`timescale 1ns/1ps
`include "dtim_macros.svh"

module dtim_ctrl (
  input  logic                           clock,
  input  logic                           reset,
  dtim_ram_if.ctrl                       tag_bus,
  dtim_ram_if.ctrl                       line_bus,
  dtim_ram_if.ctrl                       flag_bus,
  input  logic                           mem_valid,
  input  logic                           mem_fence,
  input  logic [31:0]                    mem_addr,
  input  logic [31:0]                    mem_wdata,
  input  logic [3:0]                     mem_wstrb,
  output logic [31:0]                    mem_rdata,
  output logic                           mem_ready,
  input  logic [31:0]                    dmem_rdata,
  input  logic                           dmem_ready,
  output logic                           dmem_valid,
  output logic [31:0]                    dmem_addr,
  output logic [31:0]                    dmem_wdata,
  output logic [3:0]                     dmem_wstrb,
  output logic                           load,
  output logic                           fill,
  output logic                           merge,
  output logic [`DTIM_WIDTH-1:0]         word_sel,
  output logic [31:0]                    store_data,
  output logic [3:0]                     store_strb,
  input  logic [dtim_pkg::line_bits-1:0] line_out,
  input  logic [31:0]                    word_out
);

  localparam int off_bits = `DTIM_WIDTH + 2;
  localparam logic [`DTIM_DEPTH-1:0] last_index = {`DTIM_DEPTH{1'b1}};
  localparam logic [`DTIM_WIDTH-1:0] last_word = {`DTIM_WIDTH{1'b1}};

  dtim_pkg::dtim_state_e state_q;
  dtim_pkg::dtim_state_e state_d;
  logic                  req_valid_q;
  logic                  req_valid_d;
  logic                  req_fence_q;
  logic [31:0]           req_addr_q;
  logic [31:0]           req_wdata_q;
  logic [3:0]            req_wstrb_q;
  logic [`DTIM_DEPTH-1:0] fidx_q;
  logic [`DTIM_DEPTH-1:0] fidx_d;
  logic [`DTIM_WIDTH-1:0] cnt_q;
  logic [`DTIM_WIDTH-1:0] cnt_d;
  logic                  dmem_valid_q;
  logic                  dmem_valid_d;
  logic [31:0]           dmem_addr_q;
  logic [31:0]           dmem_addr_d;
  logic [3:0]            dmem_wstrb_q;
  logic [3:0]            dmem_wstrb_d;

  logic [dtim_pkg::tag_bits-1:0] req_tag;
  logic [`DTIM_DEPTH-1:0]        req_idx;
  logic [`DTIM_WIDTH-1:0]        req_word;
  logic                          req_store;
  logic                          in_window;
  logic                          tag_match;
  logic                          fence_walk;
  logic [`DTIM_DEPTH-1:0]        rd_idx;
  logic [`DTIM_DEPTH-1:0]        wr_idx;
  dtim_pkg::dtim_flags_t         flags_rd;
  dtim_pkg::dtim_flags_t         flags_wr;

  // Request decode
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign req_tag   = req_addr_q[31 -: dtim_pkg::tag_bits];
  assign req_idx   = req_addr_q[off_bits +: `DTIM_DEPTH];
  assign req_word  = req_addr_q[2 +: `DTIM_WIDTH];
  assign req_store = |req_wstrb_q;
  assign in_window = (req_addr_q >= `DTIM_BASE_ADDR) && (req_addr_q < `DTIM_TOP_ADDR);
  assign flags_rd  = dtim_pkg::dtim_flags_t'(flag_bus.rdata);
  assign tag_match = tag_bus.rdata == req_tag;

  // Next state
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    state_d      = state_q;
    req_valid_d  = req_valid_q;
    fidx_d       = fidx_q;
    cnt_d        = cnt_q;
    dmem_valid_d = dmem_valid_q;
    dmem_addr_d  = dmem_addr_q;
    dmem_wstrb_d = dmem_wstrb_q;
    load         = 1'b0;
    fill         = 1'b0;
    merge        = 1'b0;
    word_sel     = req_word;
    mem_ready    = 1'b0;
    mem_rdata    = word_out;
    tag_bus.wen  = 1'b0;
    line_bus.wen = 1'b0;
    flag_bus.wen = 1'b0;
    flags_wr     = '0;

    case (state_q)
      dtim_pkg::st_lookup: begin
        // A load hit answers straight from the array in this cycle
        mem_rdata = line_bus.rdata[32*req_word +: 32];
        if (req_valid_q) begin
          req_valid_d = 1'b0;
          if (req_fence_q) begin
            state_d = dtim_pkg::st_fence;
            fidx_d  = '0;
          end else if (!in_window) begin
            state_d      = dtim_pkg::st_bypass;
            dmem_valid_d = 1'b1;
            dmem_addr_d  = req_addr_q;
            dmem_wstrb_d = req_wstrb_q;
          end else if (!flags_rd.present) begin
            state_d      = dtim_pkg::st_miss;
            dmem_valid_d = 1'b1;
            dmem_addr_d  = {req_addr_q[31:off_bits], {off_bits{1'b0}}};
            dmem_wstrb_d = 4'h0;
            cnt_d        = '0;
          end else if (!tag_match) begin
            // Locked by another tag, served as a single word
            state_d      = dtim_pkg::st_bypass;
            dmem_valid_d = 1'b1;
            dmem_addr_d  = req_addr_q;
            dmem_wstrb_d = req_wstrb_q;
          end else if (req_store) begin
            load    = 1'b1;
            merge   = 1'b1;
            state_d = dtim_pkg::st_update;
          end else begin
            mem_ready = 1'b1;
          end
        end
      end
      dtim_pkg::st_miss: begin
        word_sel = cnt_q;
        if (dmem_ready) begin
          fill = 1'b1;
          // A store miss merges when its own word comes back
          merge       = req_store && (cnt_q == req_word);
          cnt_d       = cnt_q + 1'b1;
          dmem_addr_d = dmem_addr_q + 32'd4;
          if (cnt_q == last_word) begin
            dmem_valid_d = 1'b0;
            state_d      = dtim_pkg::st_update;
          end
        end
      end
      dtim_pkg::st_bypass: begin
        mem_rdata = dmem_rdata;
        if (dmem_ready) begin
          mem_ready    = 1'b1;
          dmem_valid_d = 1'b0;
          state_d      = dtim_pkg::st_lookup;
        end
      end
      dtim_pkg::st_update: begin
        tag_bus.wen      = 1'b1;
        line_bus.wen     = 1'b1;
        flag_bus.wen     = 1'b1;
        flags_wr.present = 1'b1;
        flags_wr.dirty   = req_store;
        mem_ready        = 1'b1;
        state_d          = dtim_pkg::st_lookup;
      end
      dtim_pkg::st_fence: begin
        flag_bus.wen = 1'b1;
        if (flags_rd.present && flags_rd.dirty) begin
          load         = 1'b1;
          state_d      = dtim_pkg::st_writeback;
          dmem_valid_d = 1'b1;
          dmem_addr_d  = {tag_bus.rdata, fidx_q, {off_bits{1'b0}}};
          dmem_wstrb_d = 4'hf;
          cnt_d        = '0;
        end else if (fidx_q == last_index) begin
          mem_ready = 1'b1;
          state_d   = dtim_pkg::st_lookup;
        end else begin
          fidx_d = fidx_q + 1'b1;
        end
      end
      dtim_pkg::st_writeback: begin
        word_sel = cnt_q;
        if (dmem_ready) begin
          cnt_d       = cnt_q + 1'b1;
          dmem_addr_d = dmem_addr_q + 32'd4;
          // Back to the same index, whose flags are clear by now
          if (cnt_q == last_word) begin
            dmem_valid_d = 1'b0;
            state_d      = dtim_pkg::st_fence;
          end
        end
      end
      default: begin
        state_d = dtim_pkg::st_lookup;
      end
    endcase

    if (mem_valid) begin
      req_valid_d = 1'b1;
    end
  end

  // Array addressing
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign fence_walk = (state_d == dtim_pkg::st_fence) || (state_d == dtim_pkg::st_writeback);
  assign rd_idx = mem_valid  ? mem_addr[off_bits +: `DTIM_DEPTH] :
                  fence_walk ? fidx_d : req_idx;
  assign wr_idx = (state_q == dtim_pkg::st_update) ? req_idx : fidx_q;

  assign tag_bus.raddr  = rd_idx;
  assign line_bus.raddr = rd_idx;
  assign flag_bus.raddr = rd_idx;
  assign tag_bus.waddr  = wr_idx;
  assign line_bus.waddr = wr_idx;
  assign flag_bus.waddr = wr_idx;
  assign tag_bus.wdata  = req_tag;
  assign line_bus.wdata = line_out;
  assign flag_bus.wdata = flags_wr;

  assign dmem_valid = dmem_valid_q;
  assign dmem_addr  = dmem_addr_q;
  assign dmem_wstrb = dmem_wstrb_q;
  assign dmem_wdata = (state_q == dtim_pkg::st_bypass) ? req_wdata_q : word_out;
  assign store_data = req_wdata_q;
  assign store_strb = req_wstrb_q;

  always_ff @(posedge clock) begin
    if (!reset) begin
      state_q      <= dtim_pkg::st_lookup;
      req_valid_q  <= 1'b0;
      fidx_q       <= '0;
      cnt_q        <= '0;
      dmem_valid_q <= 1'b0;
    end else begin
      state_q      <= state_d;
      req_valid_q  <= req_valid_d;
      fidx_q       <= fidx_d;
      cnt_q        <= cnt_d;
      dmem_valid_q <= dmem_valid_d;
    end
  end

  always_ff @(posedge clock) begin
    if (mem_valid) begin
      req_fence_q <= mem_fence;
      req_addr_q  <= mem_addr;
      req_wdata_q <= mem_wdata;
      req_wstrb_q <= mem_wstrb;
    end
    dmem_addr_q  <= dmem_addr_d;
    dmem_wstrb_q <= dmem_wstrb_d;
  end

endmodule

/* dtim/dtim.sv */
`timescale 1ns/1ps
`include "dtim_macros.svh"

module dtim (
  input  logic        clock,
  input  logic        reset,
  input  logic        mem_valid,
  input  logic        mem_fence,
  input  logic [31:0] mem_addr,
  input  logic [31:0] mem_wdata,
  input  logic [3:0]  mem_wstrb,
  output logic [31:0] mem_rdata,
  output logic        mem_ready,
  output logic        dmem_valid,
  output logic [31:0] dmem_addr,
  output logic [31:0] dmem_wdata,
  output logic [3:0]  dmem_wstrb,
  input  logic [31:0] dmem_rdata,
  input  logic        dmem_ready
);

  logic                           load;
  logic                           fill;
  logic                           merge;
  logic [`DTIM_WIDTH-1:0]         word_sel;
  logic [31:0]                    store_data;
  logic [3:0]                     store_strb;
  logic [dtim_pkg::line_bits-1:0] line_out;
  logic [31:0]                    word_out;

  dtim_ram_if #(.data_bits(dtim_pkg::tag_bits))  tag_bus ();
  dtim_ram_if #(.data_bits(dtim_pkg::line_bits)) line_bus ();
  dtim_ram_if #(.data_bits(2))                   flag_bus ();

  dtim_ram tag_ram (
    .clock (clock),
    .ram   (tag_bus)
  );

  dtim_ram line_ram (
    .clock (clock),
    .ram   (line_bus)
  );

  dtim_ram flag_ram (
    .clock (clock),
    .ram   (flag_bus)
  );

  dtim_line_buf line_buf (
    .clock      (clock),
    .line_in    (line_bus.rdata),
    .load       (load),
    .fill       (fill),
    .merge      (merge),
    .word_sel   (word_sel),
    .fill_word  (dmem_rdata),
    .store_data (store_data),
    .store_strb (store_strb),
    .line_out   (line_out),
    .word_out   (word_out)
  );

  dtim_ctrl ctrl (
    .clock      (clock),
    .reset      (reset),
    .tag_bus    (tag_bus),
    .line_bus   (line_bus),
    .flag_bus   (flag_bus),
    .mem_valid  (mem_valid),
    .mem_fence  (mem_fence),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .mem_wstrb  (mem_wstrb),
    .mem_rdata  (mem_rdata),
    .mem_ready  (mem_ready),
    .dmem_rdata (dmem_rdata),
    .dmem_ready (dmem_ready),
    .dmem_valid (dmem_valid),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_wstrb (dmem_wstrb),
    .load       (load),
    .fill       (fill),
    .merge      (merge),
    .word_sel   (word_sel),
    .store_data (store_data),
    .store_strb (store_strb),
    .line_out   (line_out),
    .word_out   (word_out)
  );

endmodule

/* dv/dtim_asserts.sv */
`timescale 1ns/1ps

module dtim_asserts (
  input logic        clock,
  input logic        reset,
  input logic        mem_valid,
  input logic        mem_ready,
  input logic        dmem_valid,
  input logic        dmem_ready,
  input logic [31:0] dmem_addr,
  input logic [31:0] dmem_wdata,
  input logic [3:0]  dmem_wstrb
);

  logic pending;

  // A request is open from mem_valid until its mem_ready
  always_ff @(posedge clock) begin
    if (!reset) begin
      pending <= 1'b0;
    end else if (mem_valid) begin
      pending <= 1'b1;
    end else if (mem_ready) begin
      pending <= 1'b0;
    end
  end

  stable_backing: assert property (@(posedge clock) disable iff (!reset)
    (dmem_valid && !dmem_ready) |=>
      ($stable(dmem_addr) && $stable(dmem_wdata) && $stable(dmem_wstrb)))
    else $error("backing request changed while waiting for dmem_ready");

  ready_needs_request: assert property (@(posedge clock) disable iff (!reset)
    mem_ready |-> pending)
    else $error("mem_ready without an open request");

  quiet_in_reset: assert property (@(posedge clock)
    !reset |-> (!mem_ready && !dmem_valid))
    else $error("mem_ready or dmem_valid high during reset");

endmodule

bind dtim dtim_asserts asserts (.*);

/* dv/dtim_tb.sv */
`timescale 1ns/1ps
`include "dtim_macros.svh"

module dtim_tb;

  localparam int cycle_limit = 20000;

  logic        clock = 1'b0;
  logic        reset;
  logic        mem_valid;
  logic        mem_fence;
  logic [31:0] mem_addr;
  logic [31:0] mem_wdata;
  logic [3:0]  mem_wstrb;
  logic [31:0] mem_rdata;
  logic        mem_ready;
  logic        dmem_valid;
  logic [31:0] dmem_addr;
  logic [31:0] dmem_wdata;
  logic [3:0]  dmem_wstrb;
  logic [31:0] dmem_rdata;
  logic        dmem_ready;

  logic [31:0] lcg_state = 32'hfe7a_9414;
  logic [31:0] back_mem [logic [31:0]];
  logic [31:0] model [logic [31:0]];
  int          cycles = 0;
  int          errors = 0;
  int          tests_passed = 0;
  int          tests_failed = 0;
  int          dmem_count = 0;
  int          delay_left = -1;
  logic [31:0] last_addr;
  logic [3:0]  last_strb;
  logic        exp_check;
  logic [31:0] exp_data;
  logic                          held_v [2**`DTIM_DEPTH];
  logic [dtim_pkg::tag_bits-1:0] held_tag [2**`DTIM_DEPTH];

  dtim DUT (.*);

  always #20 clock = ~clock;

  function automatic logic [31:0] lcg();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Every address starts out with its own value
  function automatic logic [31:0] fill_pattern(input logic [31:0] a);
    return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]};
  endfunction

  function automatic logic [31:0] ref_read(input logic [31:0] a);
    logic [31:0] w;
    w = {a[31:2], 2'b00};
    if (model.exists(w)) begin
      return model[w];
    end
    return fill_pattern(w);
  endfunction

  function automatic logic [31:0] back_read(input logic [31:0] a);
    logic [31:0] w;
    w = {a[31:2], 2'b00};
    if (back_mem.exists(w)) begin
      return back_mem[w];
    end
    return fill_pattern(w);
  endfunction

  function automatic logic in_window(input logic [31:0] a);
    return (a >= `DTIM_BASE_ADDR) && (a < `DTIM_TOP_ADDR);
  endfunction

  function automatic logic line_held(input logic [31:0] a);
    return held_v[a[`DTIM_WIDTH+2 +: `DTIM_DEPTH]];
  endfunction

  // A held index answers only to the tag that filled it
  function automatic logic is_conflict(input logic [31:0] a);
    return in_window(a) && line_held(a) &&
           held_tag[a[`DTIM_WIDTH+2 +: `DTIM_DEPTH]] != a[31 -: dtim_pkg::tag_bits];
  endfunction

  task automatic note_line(input logic [31:0] a);
    if (in_window(a) && !line_held(a)) begin
      held_v[a[`DTIM_WIDTH+2 +: `DTIM_DEPTH]] = 1'b1;
      held_tag[a[`DTIM_WIDTH+2 +: `DTIM_DEPTH]] = a[31 -: dtim_pkg::tag_bits];
    end
  endtask

  // Backing memory with a random answer delay
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always @(negedge clock) begin
    logic [31:0] val;
    dmem_ready = 1'b0;
    if (reset && dmem_valid) begin
      if (delay_left < 0) begin
        delay_left = int'(lcg() % 4);
      end
      if (delay_left == 0) begin
        val = back_read(dmem_addr);
        for (int b = 0; b < 4; b++) begin
          if (dmem_wstrb[b]) begin
            val[8*b +: 8] = dmem_wdata[8*b +: 8];
          end
        end
        if (dmem_wstrb != 4'h0) begin
          back_mem[{dmem_addr[31:2], 2'b00}] = val;
        end
        dmem_rdata = val;
        dmem_ready = 1'b1;
        dmem_count++;
        last_addr = dmem_addr;
        last_strb = dmem_wstrb;
        delay_left = -1;
      end else begin
        delay_left--;
      end
    end
  end

  always @(posedge clock) begin
    if (reset && mem_ready && exp_check) begin
      if (mem_rdata !== exp_data) begin
        $display("Error: mem_rdata got %h expected %h", mem_rdata, exp_data);
        errors++;
      end
    end
  end

  always @(posedge clock) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("Timeout: the run went past %0d cycles", cycle_limit);
      $display("Simulation failed");
      $finish;
    end
  end

  // One core request, waits for mem_ready
  task automatic access(input logic fence, input logic [31:0] addr, input logic [31:0] data,
                        input logic [3:0] strb, output int lat, output int fills);
    int start_count;
    start_count = dmem_count;
    @(negedge clock);
    exp_check = !fence && (strb == 4'h0);
    exp_data = ref_read(addr);
    mem_valid = 1'b1;
    mem_fence = fence;
    mem_addr = addr;
    mem_wdata = data;
    mem_wstrb = strb;
    @(negedge clock);
    mem_valid = 1'b0;
    mem_fence = 1'b0;
    mem_wstrb = 4'h0;
    lat = 1;
    @(posedge clock);
    while (!mem_ready) begin
      @(posedge clock);
      lat++;
    end
    if (!fence && strb != 4'h0) begin
      exp_data = ref_read(addr);
      for (int b = 0; b < 4; b++) begin
        if (strb[b]) begin
          exp_data[8*b +: 8] = data[8*b +: 8];
        end
      end
      model[{addr[31:2], 2'b00}] = exp_data;
    end
    if (!fence) begin
      note_line(addr);
    end
    fills = dmem_count - start_count;
  endtask

  task automatic end_test(input string name, input int start_errors);
    if (errors == start_errors) begin
      tests_passed++;
      $display("Test %s: ok", name);
    end else begin
      tests_failed++;
      $display("Test %s: %0d errors", name, errors - start_errors);
    end
  endtask

  initial begin : main
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] r;
    logic [31:0] d;
    logic [31:0] keep_addr;
    logic [3:0]  s;
    int          lat;
    int          fills;
    int          exp_fills;
    int          start;

    reset = 1'b0;
    mem_valid = 1'b0;
    mem_fence = 1'b0;
    mem_addr = '0;
    mem_wdata = '0;
    mem_wstrb = '0;
    dmem_rdata = '0;
    dmem_ready = 1'b0;
    exp_check = 1'b0;
    exp_data = '0;
    keep_addr = `DTIM_BASE_ADDR;
    for (int i = 0; i < 2**`DTIM_DEPTH; i++) begin
      held_v[i] = 1'b0;
      held_tag[i] = '0;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    start = errors;
    for (int i = 0; i < 11; i++) begin
      if (i == 8) begin
        @(negedge clock);
        reset = 1'b1;
      end
      @(posedge clock);
      if (mem_ready !== 1'b0) begin
        $display("Error: mem_ready got %h expected %h", mem_ready, 1'b0);
        errors++;
      end
      if (dmem_valid !== 1'b0) begin
        $display("Error: dmem_valid got %h expected %h", dmem_valid, 1'b0);
        errors++;
      end
    end
    end_test("reset", start);

    start = errors;
    for (int i = 0; i < 8; i++) begin
      r = lcg();
      a = `DTIM_BASE_ADDR + {22'b0, r[25:18], 2'b00};
      if (!is_conflict(a)) begin
        exp_fills = line_held(a) ? 0 : 4;
        access(1'b0, a, '0, 4'h0, lat, fills);
        if (fills != exp_fills) begin
          $display("Error: backing reads got %h expected %h", fills, exp_fills);
          errors++;
        end
        keep_addr = a;
        b = {a[31:4], r[3:2], 2'b00};
        access(1'b0, b, '0, 4'h0, lat, fills);
        if (fills != 0) begin
          $display("Error: backing reads got %h expected %h", fills, 0);
          errors++;
        end
        if (lat != 1) begin
          $display("Error: mem_ready latency got %h expected %h", lat, 1);
          errors++;
        end
      end
    end
    end_test("load miss then hit", start);

    start = errors;
    for (int i = 0; i < 12; i++) begin
      r = lcg();
      a = `DTIM_BASE_ADDR + {22'b0, r[25:18], 2'b00};
      s = (r[13:10] == 4'h0) ? 4'h1 : r[13:10];
      d = lcg();
      access(1'b0, a, d, s, lat, fills);
      access(1'b0, a, '0, 4'h0, lat, fills);
    end
    end_test("byte stores", start);

    start = errors;
    r = lcg();
    a = 32'h0000_8000 + {20'b0, r[11:2], 2'b00};
    s = (r[15:12] == 4'h0) ? 4'h3 : r[15:12];
    access(1'b0, a, '0, 4'h0, lat, fills);
    if (fills != 1) begin
      $display("Error: bypass load backing accesses got %h expected %h", fills, 1);
      errors++;
    end
    if (last_addr !== a) begin
      $display("Error: bypass load dmem_addr got %h expected %h", last_addr, a);
      errors++;
    end
    if (last_strb !== 4'h0) begin
      $display("Error: bypass load dmem_wstrb got %h expected %h", last_strb, 4'h0);
      errors++;
    end
    access(1'b0, a, lcg(), s, lat, fills);
    if (fills != 1) begin
      $display("Error: bypass store backing accesses got %h expected %h", fills, 1);
      errors++;
    end
    if (last_addr !== a) begin
      $display("Error: bypass store dmem_addr got %h expected %h", last_addr, a);
      errors++;
    end
    if (last_strb !== s) begin
      $display("Error: bypass store dmem_wstrb got %h expected %h", last_strb, s);
      errors++;
    end
    access(1'b0, a, '0, 4'h0, lat, fills);
    end_test("bypass", start);

    start = errors;
    b = keep_addr ^ 32'h0000_0100;
    access(1'b0, b, '0, 4'h0, lat, fills);
    if (fills != 1) begin
      $display("Error: conflict load backing accesses got %h expected %h", fills, 1);
      errors++;
    end
    if (last_addr !== b) begin
      $display("Error: conflict load dmem_addr got %h expected %h", last_addr, b);
      errors++;
    end
    access(1'b0, b, lcg(), 4'h6, lat, fills);
    if (fills != 1) begin
      $display("Error: conflict store backing accesses got %h expected %h", fills, 1);
      errors++;
    end
    if (last_addr !== b) begin
      $display("Error: conflict store dmem_addr got %h expected %h", last_addr, b);
      errors++;
    end
    if (last_strb !== 4'h6) begin
      $display("Error: conflict store dmem_wstrb got %h expected %h", last_strb, 4'h6);
      errors++;
    end
    access(1'b0, b, '0, 4'h0, lat, fills);
    access(1'b0, keep_addr, '0, 4'h0, lat, fills);
    if (fills != 0) begin
      $display("Error: held line backing reads got %h expected %h", fills, 0);
      errors++;
    end
    if (lat != 1) begin
      $display("Error: held line mem_ready latency got %h expected %h", lat, 1);
      errors++;
    end
    end_test("tag conflict", start);

    start = errors;
    access(1'b1, '0, '0, 4'h0, lat, fills);
    foreach (model[k]) begin
      if (back_read(k) !== model[k]) begin
        $display("Error: backing word %h got %h expected %h", k, back_read(k), model[k]);
        errors++;
      end
    end
    for (int i = 0; i < 2**`DTIM_DEPTH; i++) begin
      held_v[i] = 1'b0;
    end
    access(1'b0, keep_addr, '0, 4'h0, lat, fills);
    if (fills != 4) begin
      $display("Error: refill after fence backing reads got %h expected %h", fills, 4);
      errors++;
    end
    end_test("fence", start);

    $display("Tests passed %0d, tests failed %0d, errors %0d",
             tests_passed, tests_failed, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* sources.f */
+incdir+common
common/dtim_pkg.sv
common/dtim_ram_if.sv
logic/dtim_ram.sv
dtim/dtim_line_buf.sv
dtim/dtim_ctrl.sv
dtim/dtim.sv
dv/dtim_asserts.sv
dv/dtim_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module dtim_tb -f sources.f \
  -o dtim_sim > build.log 2>&1 && ./obj_dir/dtim_sim > sim.log 2>&1 || {
  echo "build or run error, see build.log and sim.log"; exit 1; }
cat sim.log
grep -q "Simulation failed" sim.log && exit 1
grep -q "Simulation passed" sim.log || exit 1
exit 0
